// ==== filelist.f ====
+incdir+include
hw/mos_mem_pkg.sv
hw/mos_byte_mem.sv
hw/mos_inst_fetch.sv
hw/mos_ptr_resolve.sv
hw/mos_axil_regs.sv
hw/mos_mem_top.sv
tb/mos_mem_tb.sv

// ==== hw/mos_axil_regs.sv ====
`include "mos_consts.svh"
`default_nettype none

module mos_axil_regs
    import mos_mem_pkg::*;
(
    input  wire                              clk_i,
    input  wire                              reset_i,
    input  wire  [`MOS_AXIL_ADR_WIDTH-1:0]   axil_awaddr_i,
    input  wire                              axil_awvalid_i,
    output logic                             axil_awready_o,
    input  wire  [`MOS_AXIL_DAT_WIDTH-1:0]   axil_wdata_i,
    input  wire                              axil_wvalid_i,
    output logic                             axil_wready_o,
    output logic [1:0]                       axil_bresp_o,
    output logic                             axil_bvalid_o,
    input  wire                              axil_bready_i,
    input  wire  [`MOS_AXIL_ADR_WIDTH-1:0]   axil_araddr_i,
    input  wire                              axil_arvalid_i,
    output logic                             axil_arready_o,
    output logic [`MOS_AXIL_DAT_WIDTH-1:0]   axil_rdata_o,
    output logic [1:0]                       axil_rresp_o,
    output logic                             axil_rvalid_o,
    input  wire                              axil_rready_i,
    output mos_wr_cmd_t                      wr_cmd_o,
    input  wire                              stall_i,
    output logic [`MOS_ADR_WIDTH-1:0]        rd_adr_o,
    input  wire  [`MOS_DAT_WIDTH-1:0]        rd_dat_i,
    output logic [`MOS_ADR_WIDTH-1:0]        pc_o,
    input  wire mos_decode_t                 decode_i,
    input  wire  [2*`MOS_DAT_WIDTH-1:0]      pointer_i
);

    mos_axil_state_e                    state_q;
    mos_wr_cmd_t                        wr_cmd_q;
    logic [`MOS_ADR_WIDTH-1:0]          addr_q;
    logic [`MOS_ADR_WIDTH-1:0]          pc_q;
    logic [1:0]                         bresp_q;
    logic                               rvalid_q;
    logic [`MOS_AXIL_DAT_WIDTH-1:0]     rdata_q;
    logic [1:0]                         rresp_q;
    logic [`MOS_AXIL_DAT_WIDTH-1:0]     rd_word;
    logic [1:0]                         rd_resp;
    logic                               wr_accept;

    ////////////////////
    // write channel
    ////////////////////

    assign wr_accept = (state_q == AXIL_IDLE) && axil_awvalid_i && axil_wvalid_i;
    assign axil_awready_o = wr_accept;
    assign axil_wready_o = wr_accept;
    assign axil_bvalid_o = (state_q == AXIL_RESP);
    assign axil_bresp_o = bresp_q;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            state_q <= AXIL_IDLE;
            addr_q <= '0;
            pc_q <= '0;
            bresp_q <= `MOS_AXI_RESP_OKAY;
            wr_cmd_q.valid <= 1'b0;
        end
        else
        begin
            wr_cmd_q.valid <= 1'b0;
            case (state_q)
                AXIL_IDLE:
                if (wr_accept)
                begin
                    bresp_q <= `MOS_AXI_RESP_OKAY;
                    state_q <= AXIL_RESP;
                    case (axil_awaddr_i)
                        `MOS_REG_ADDR: addr_q <= axil_wdata_i[15:0];
                        `MOS_REG_PC: pc_q <= axil_wdata_i[15:0];
                        `MOS_REG_WDATA:
                        begin
                            wr_cmd_q <= '{valid: 1'b1, adr: addr_q,
                                          cnt: axil_wdata_i[25:24],
                                          dat: axil_wdata_i[23:0]};
                            state_q <= AXIL_WR_MEM;
                        end
                        // read-only registers ignore writes
                        `MOS_REG_RDATA, `MOS_REG_DECODE, `MOS_REG_POINTER: ;
                        default: bresp_q <= `MOS_AXI_RESP_SLVERR;
                    endcase
                end
                // the stall only shows up one clock after the command is taken
                AXIL_WR_MEM:
                if (!wr_cmd_q.valid && !stall_i)
                begin
                    state_q <= AXIL_RESP;
                end
                AXIL_RESP:
                if (axil_bready_i)
                begin
                    state_q <= AXIL_IDLE;
                end
                default: state_q <= AXIL_IDLE;
            endcase
        end
    end

    assign wr_cmd_o = wr_cmd_q;
    assign rd_adr_o = addr_q;
    assign pc_o = pc_q;

    ////////////////////
    // read channel
    ////////////////////

    // decode word is {legal, 5'b0, len, operand, opcode}
    always_comb
    begin
        rd_resp = `MOS_AXI_RESP_OKAY;
        case (axil_araddr_i)
            `MOS_REG_ADDR: rd_word = {16'd0, addr_q};
            `MOS_REG_WDATA: rd_word = {6'd0, wr_cmd_q.cnt, wr_cmd_q.dat};
            `MOS_REG_RDATA: rd_word = {24'd0, rd_dat_i};
            `MOS_REG_PC: rd_word = {16'd0, pc_q};
            `MOS_REG_DECODE:
                rd_word = {decode_i.legal, 5'd0, decode_i.len, decode_i.operand,
                           decode_i.opcode};
            `MOS_REG_POINTER: rd_word = {16'd0, pointer_i};
            default:
            begin
                rd_word = '0;
                rd_resp = `MOS_AXI_RESP_SLVERR;
            end
        endcase
    end

    assign axil_arready_o = axil_arvalid_i && !rvalid_q;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            rvalid_q <= 1'b0;
        end
        else if (axil_arready_o)
        begin
            rvalid_q <= 1'b1;
        end
        else if (axil_rready_i)
        begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (axil_arready_o)
        begin
            rdata_q <= rd_word;
            rresp_q <= rd_resp;
        end
    end

    assign axil_rvalid_o = rvalid_q;
    assign axil_rdata_o = rdata_q;
    assign axil_rresp_o = rresp_q;

    a_bvalid_hold: assert property (
        @(posedge clk_i) disable iff (reset_i)
        axil_bvalid_o && !axil_bready_i |=> axil_bvalid_o && $stable(axil_bresp_o)
    );

    a_rvalid_hold: assert property (
        @(posedge clk_i) disable iff (reset_i)
        axil_rvalid_o && !axil_rready_i |=> axil_rvalid_o && $stable(axil_rdata_o)
    );

endmodule

`default_nettype wire

// ==== hw/mos_byte_mem.sv ====
`include "mos_consts.svh"
`default_nettype none

module mos_byte_mem
    import mos_mem_pkg::*;
(
    input  wire                              clk_i,
    input  wire mos_wr_cmd_t                 wr_cmd_i,
    output logic                             stall_o,
    input  wire  [`MOS_ADR_WIDTH-1:0]        op_adr_i,
    output logic [`MOS_DAT_WIDTH-1:0]        op_dat_o,
    input  wire  [`MOS_ADR_WIDTH-1:0]        if_adr_i,
    input  wire  [1:0]                       if_cnt_i,
    output logic [3*`MOS_DAT_WIDTH-1:0]      if_dat_o,
    input  wire  [`MOS_ADR_WIDTH-1:0]        ea_adr_i,
    output logic [2*`MOS_DAT_WIDTH-1:0]      ea_dat_o,
    input  wire  [`MOS_ADR_WIDTH-1:0]        rd_adr_i,
    output logic [`MOS_DAT_WIDTH-1:0]        rd_dat_o
);

    logic [`MOS_DAT_WIDTH-1:0]      mem_q [0:`MOS_MEM_DEPTH-1];

    // bytes still to be written by a multi-byte command
    logic [1:0]                     cnt_q;
    logic [`MOS_ADR_WIDTH-1:0]      adr_q;
    logic [3*`MOS_DAT_WIDTH-1:0]    dat_q;
    logic [1:0]                     top_idx;
    logic [`MOS_ADR_WIDTH-1:0]      if_adr_1;
    logic [`MOS_ADR_WIDTH-1:0]      if_adr_2;

    assign stall_o = (cnt_q != 2'd0);
    assign top_idx = cnt_q - 2'd1;

    ////////////////////
    // write side
    ////////////////////

    // a single byte goes straight in, longer commands drain from the top byte down
    always_ff @(posedge clk_i)
    begin
        if (cnt_q != 2'd0)
        begin
            mem_q[adr_q + {14'd0, top_idx}] <= dat_q[{top_idx, 3'b000} +: `MOS_DAT_WIDTH];
            cnt_q <= top_idx;
        end
        else if (wr_cmd_i.valid)
        begin
            if (wr_cmd_i.cnt == 2'd1)
            begin
                mem_q[wr_cmd_i.adr] <= wr_cmd_i.dat[`MOS_DAT_WIDTH-1:0];
            end
            else if (wr_cmd_i.cnt != 2'd0)
            begin
                cnt_q <= wr_cmd_i.cnt;
                adr_q <= wr_cmd_i.adr;
                dat_q <= wr_cmd_i.dat;
            end
        end
    end

    ////////////////////
    // read ports
    ////////////////////

    assign if_adr_1 = if_adr_i + 16'd1;
    assign if_adr_2 = if_adr_i + 16'd2;

    assign op_dat_o = mem_q[op_adr_i];
    assign rd_dat_o = mem_q[rd_adr_i];
    assign ea_dat_o = {mem_q[ea_adr_i + 16'd1], mem_q[ea_adr_i]};

    // bytes past the requested count read as ff
    always_comb
    begin
        case (if_cnt_i)
            2'd1: if_dat_o = {16'hFFFF, mem_q[if_adr_i]};
            2'd2: if_dat_o = {8'hFF, mem_q[if_adr_1], mem_q[if_adr_i]};
            2'd3: if_dat_o = {mem_q[if_adr_2], mem_q[if_adr_1], mem_q[if_adr_i]};
            default: if_dat_o = 24'hFFFFFF;
        endcase
    end

    // the host side must hold off while a long write drains
    a_no_cmd_in_stall: assert property (
        @(posedge clk_i) stall_o |-> !wr_cmd_i.valid
    );

    a_stall_bound: assert property (
        @(posedge clk_i) $rose(stall_o) |-> ##[1:3] !stall_o
    );

endmodule

`default_nettype wire

// ==== hw/mos_inst_fetch.sv ====
`include "mos_consts.svh"
`default_nettype none

module mos_inst_fetch
    import mos_mem_pkg::*;
(
    input  wire                              clk_i,
    input  wire                              reset_i,
    input  wire  [`MOS_ADR_WIDTH-1:0]        pc_i,
    output logic [`MOS_ADR_WIDTH-1:0]        op_adr_o,
    input  wire  [`MOS_DAT_WIDTH-1:0]        op_dat_i,
    output logic [`MOS_ADR_WIDTH-1:0]        if_adr_o,
    output logic [1:0]                       if_cnt_o,
    input  wire  [3*`MOS_DAT_WIDTH-1:0]      if_dat_i,
    output mos_decode_t                      decode_o
);

    logic [1:0]                 len;
    logic                       legal;
    logic [`MOS_ADR_WIDTH-1:0]  operand;
    mos_decode_t                decode_q;

    assign op_adr_o = pc_i;
    assign if_adr_o = pc_i;
    assign if_cnt_o = len;

    // instruction length from the 6502 table
    always_comb
    begin
        legal = 1'b1;
        case (mos_opcode_e'(op_dat_i))
            OP_TAX, OP_DEY:
                len = 2'd1;
            OP_LDA_IMM, OP_LDA_ZPG, OP_LDY_IMM, OP_BNE:
                len = 2'd2;
            OP_LDA_ABS, OP_STA_ABS, OP_ADC_ABS, OP_STX_ABS, OP_JMP_IND:
                len = 2'd3;
            default:
            begin
                len = 2'd1;
                legal = 1'b0;
            end
        endcase
    end

    // operand bytes follow the opcode, low byte first
    always_comb
    begin
        case (len)
            2'd2: operand = {8'h00, if_dat_i[15:8]};
            2'd3: operand = if_dat_i[23:8];
            default: operand = '0;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            decode_q <= '0;
        end
        else
        begin
            decode_q <= '{opcode: op_dat_i, len: len, operand: operand, legal: legal};
        end
    end

    assign decode_o = decode_q;

    a_len_nonzero: assert property (
        @(posedge clk_i) !reset_i |=> decode_q.len != 2'd0
    );

endmodule

`default_nettype wire

// ==== hw/mos_mem_pkg.sv ====
`include "mos_consts.svh"
`default_nettype none

package mos_mem_pkg;

    ////////////////////
    // opcodes
    ////////////////////

    // only the opcodes the decoder knows, anything else decodes as illegal
    typedef enum logic [7:0] {
        OP_LDA_IMM = 8'hA9,
        OP_LDA_ZPG = 8'hA5,
        OP_LDA_ABS = 8'hAD,
        OP_STA_ABS = 8'h8D,
        OP_LDY_IMM = 8'hA0,
        OP_TAX     = 8'hAA,
        OP_ADC_ABS = 8'h6D,
        OP_STX_ABS = 8'h8E,
        OP_DEY     = 8'h88,
        OP_BNE     = 8'hD0,
        OP_JMP_IND = 8'h6C
    } mos_opcode_e;

    ////////////////////
    // structs
    ////////////////////

    // byte k of dat lands at adr + k
    typedef struct packed {
        logic                            valid;
        logic [`MOS_ADR_WIDTH-1:0]       adr;
        logic [1:0]                      cnt;
        logic [3*`MOS_DAT_WIDTH-1:0]     dat;
    } mos_wr_cmd_t;

    typedef struct packed {
        logic [`MOS_DAT_WIDTH-1:0]       opcode;
        logic [1:0]                      len;
        logic [`MOS_ADR_WIDTH-1:0]       operand;
        logic                            legal;
    } mos_decode_t;

    ////////////////////
    // state machines
    ////////////////////

    typedef enum logic [1:0] {
        AXIL_IDLE,
        AXIL_WR_MEM,
        AXIL_RESP
    } mos_axil_state_e;

endpackage

`default_nettype wire

// ==== hw/mos_mem_top.sv ====
`include "mos_consts.svh"
`default_nettype none

module mos_mem_top
    import mos_mem_pkg::*;
(
    input  wire                              clk_i,
    input  wire                              reset_i,
    input  wire  [`MOS_AXIL_ADR_WIDTH-1:0]   axil_awaddr_i,
    input  wire                              axil_awvalid_i,
    output logic                             axil_awready_o,
    input  wire  [`MOS_AXIL_DAT_WIDTH-1:0]   axil_wdata_i,
    input  wire                              axil_wvalid_i,
    output logic                             axil_wready_o,
    output logic [1:0]                       axil_bresp_o,
    output logic                             axil_bvalid_o,
    input  wire                              axil_bready_i,
    input  wire  [`MOS_AXIL_ADR_WIDTH-1:0]   axil_araddr_i,
    input  wire                              axil_arvalid_i,
    output logic                             axil_arready_o,
    output logic [`MOS_AXIL_DAT_WIDTH-1:0]   axil_rdata_o,
    output logic [1:0]                       axil_rresp_o,
    output logic                             axil_rvalid_o,
    input  wire                              axil_rready_i
);

    mos_wr_cmd_t                    wr_cmd;
    logic                           stall;
    logic [`MOS_ADR_WIDTH-1:0]      op_adr;
    logic [`MOS_DAT_WIDTH-1:0]      op_dat;
    logic [`MOS_ADR_WIDTH-1:0]      if_adr;
    logic [1:0]                     if_cnt;
    logic [3*`MOS_DAT_WIDTH-1:0]    if_dat;
    logic [`MOS_ADR_WIDTH-1:0]      ea_adr;
    logic [2*`MOS_DAT_WIDTH-1:0]    ea_dat;
    logic [`MOS_ADR_WIDTH-1:0]      rd_adr;
    logic [`MOS_DAT_WIDTH-1:0]      rd_dat;
    logic [`MOS_ADR_WIDTH-1:0]      pc;
    mos_decode_t                    decode;
    logic [2*`MOS_DAT_WIDTH-1:0]    pointer;

    mos_byte_mem i_mem (
        .clk_i    (clk_i),
        .wr_cmd_i (wr_cmd),
        .stall_o  (stall),
        .op_adr_i (op_adr),
        .op_dat_o (op_dat),
        .if_adr_i (if_adr),
        .if_cnt_i (if_cnt),
        .if_dat_o (if_dat),
        .ea_adr_i (ea_adr),
        .ea_dat_o (ea_dat),
        .rd_adr_i (rd_adr),
        .rd_dat_o (rd_dat)
    );

    mos_inst_fetch i_fetch (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .pc_i     (pc),
        .op_adr_o (op_adr),
        .op_dat_i (op_dat),
        .if_adr_o (if_adr),
        .if_cnt_o (if_cnt),
        .if_dat_i (if_dat),
        .decode_o (decode)
    );

    mos_ptr_resolve i_ptr (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .decode_i  (decode),
        .ea_adr_o  (ea_adr),
        .ea_dat_i  (ea_dat),
        .pointer_o (pointer)
    );

    mos_axil_regs i_regs (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .axil_awaddr_i  (axil_awaddr_i),
        .axil_awvalid_i (axil_awvalid_i),
        .axil_awready_o (axil_awready_o),
        .axil_wdata_i   (axil_wdata_i),
        .axil_wvalid_i  (axil_wvalid_i),
        .axil_wready_o  (axil_wready_o),
        .axil_bresp_o   (axil_bresp_o),
        .axil_bvalid_o  (axil_bvalid_o),
        .axil_bready_i  (axil_bready_i),
        .axil_araddr_i  (axil_araddr_i),
        .axil_arvalid_i (axil_arvalid_i),
        .axil_arready_o (axil_arready_o),
        .axil_rdata_o   (axil_rdata_o),
        .axil_rresp_o   (axil_rresp_o),
        .axil_rvalid_o  (axil_rvalid_o),
        .axil_rready_i  (axil_rready_i),
        .wr_cmd_o       (wr_cmd),
        .stall_i        (stall),
        .rd_adr_o       (rd_adr),
        .rd_dat_i       (rd_dat),
        .pc_o           (pc),
        .decode_i       (decode),
        .pointer_i      (pointer)
    );

endmodule

`default_nettype wire

// ==== hw/mos_ptr_resolve.sv ====
`include "mos_consts.svh"
`default_nettype none

module mos_ptr_resolve
    import mos_mem_pkg::*;
(
    input  wire                              clk_i,
    input  wire                              reset_i,
    input  wire mos_decode_t                 decode_i,
    output logic [`MOS_ADR_WIDTH-1:0]        ea_adr_o,
    input  wire  [2*`MOS_DAT_WIDTH-1:0]      ea_dat_i,
    output logic [2*`MOS_DAT_WIDTH-1:0]      pointer_o
);

    logic [2*`MOS_DAT_WIDTH-1:0]    pointer_q;

    // the operand is already zero page or absolute, the memory wraps the second byte
    assign ea_adr_o = decode_i.operand;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            pointer_q <= '0;
        end
        else if (decode_i.len >= 2'd2)
        begin
            pointer_q <= ea_dat_i;
        end
        else
        begin
            pointer_q <= '0;
        end
    end

    assign pointer_o = pointer_q;

endmodule

`default_nettype wire

// ==== include/mos_consts.svh ====
`default_nettype none
`ifndef MOS_CONSTS_SVH
`define MOS_CONSTS_SVH

// memory geometry fixed by the 6502 address space
`define MOS_ADR_WIDTH       16
`define MOS_DAT_WIDTH       8
`define MOS_MEM_DEPTH       65536

// host bus widths
`define MOS_AXIL_ADR_WIDTH  8
`define MOS_AXIL_DAT_WIDTH  32

// register map, byte offsets
`define MOS_REG_ADDR        8'h00
`define MOS_REG_WDATA       8'h04
`define MOS_REG_RDATA       8'h08
`define MOS_REG_PC          8'h0C
`define MOS_REG_DECODE      8'h10
`define MOS_REG_POINTER     8'h14

// response codes
`define MOS_AXI_RESP_OKAY   2'b00
`define MOS_AXI_RESP_SLVERR 2'b10

`endif
`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f filelist.f \
        --top-module mos_mem_tb -o mos_mem_sim \
    && ./obj_dir/mos_mem_sim | tee /dev/stderr | grep -qx "test passed" \
    && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }

// ==== tb/mos_mem_tb.sv ====
`include "mos_consts.svh"
`default_nettype none

module mos_mem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 64;
    // outputs are sampled this long after the falling edge
    localparam int SETTLE = 2;

    logic                               clk;
    logic                               reset;
    logic [`MOS_AXIL_ADR_WIDTH-1:0]     axil_awaddr;
    logic                               axil_awvalid;
    logic                               axil_awready;
    logic [`MOS_AXIL_DAT_WIDTH-1:0]     axil_wdata;
    logic                               axil_wvalid;
    logic                               axil_wready;
    logic [1:0]                         axil_bresp;
    logic                               axil_bvalid;
    logic                               axil_bready;
    logic [`MOS_AXIL_ADR_WIDTH-1:0]     axil_araddr;
    logic                               axil_arvalid;
    logic                               axil_arready;
    logic [`MOS_AXIL_DAT_WIDTH-1:0]     axil_rdata;
    logic [1:0]                         axil_rresp;
    logic                               axil_rvalid;
    logic                               axil_rready;

    logic [7:0]     model [0:`MOS_MEM_DEPTH-1];
    logic [31:0]    lfsr_q;
    int             checks;
    int             errors;
    int             timeouts;
    int             checks_mark;
    int             errors_mark;
    int             stall_run;

    mos_mem_top i_dut (
        .clk_i          (clk),
        .reset_i        (reset),
        .axil_awaddr_i  (axil_awaddr),
        .axil_awvalid_i (axil_awvalid),
        .axil_awready_o (axil_awready),
        .axil_wdata_i   (axil_wdata),
        .axil_wvalid_i  (axil_wvalid),
        .axil_wready_o  (axil_wready),
        .axil_bresp_o   (axil_bresp),
        .axil_bvalid_o  (axil_bvalid),
        .axil_bready_i  (axil_bready),
        .axil_araddr_i  (axil_araddr),
        .axil_arvalid_i (axil_arvalid),
        .axil_arready_o (axil_arready),
        .axil_rdata_o   (axil_rdata),
        .axil_rresp_o   (axil_rresp),
        .axil_rvalid_o  (axil_rvalid),
        .axil_rready_i  (axil_rready)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // protocol monitors
    ////////////////////

    always @(posedge clk)
    begin
        if (reset || !i_dut.stall)
            stall_run <= 0;
        else
            stall_run <= stall_run + 1;
    end

    a_stall_run: assert property (@(posedge clk) stall_run <= 3)
    else
    begin
        errors++;
        $display("stall stayed high for more than three cycles at %0t", $time);
    end

    a_bresp_hold: assert property (
        @(posedge clk) disable iff (reset)
        axil_bvalid && !axil_bready |=> axil_bvalid && $stable(axil_bresp)
    )
    else
    begin
        errors++;
        $display("write response dropped or changed while bready was low at %0t", $time);
    end

    a_rdata_hold: assert property (
        @(posedge clk) disable iff (reset)
        axil_rvalid && !axil_rready |=> axil_rvalid && $stable(axil_rdata)
    )
    else
    begin
        errors++;
        $display("read response dropped or changed while rready was low at %0t", $time);
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0000_0000);
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            val = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // 6502 instruction length, 0 for opcodes outside the decoded set
    function automatic logic [1:0] op_len(input logic [7:0] op);
        case (op)
            8'hAA, 8'h88:
                op_len = 2'd1;
            8'hA9, 8'hA5, 8'hA0, 8'hD0:
                op_len = 2'd2;
            8'hAD, 8'h8D, 8'h6D, 8'h8E, 8'h6C:
                op_len = 2'd3;
            default:
                op_len = 2'd0;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("timeout at %0t: %s did not arrive within %0d cycles", $time, what, TIMEOUT);
    endtask

    task automatic finish_test(input string name);
        $display("%-20s checks %0d, errors %0d", name, checks - checks_mark,
                 errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
    endtask

    ////////////////////
    // bus tasks
    ////////////////////

    task automatic axil_write(input logic [7:0] adr, input logic [31:0] dat, input int hold,
                              output logic [1:0] resp, output int stalls);
        int waited;
        @(negedge clk);
        axil_awaddr = adr;
        axil_wdata = dat;
        axil_awvalid = 1'b1;
        axil_wvalid = 1'b1;
        axil_bready = 1'b0;
        #SETTLE;
        waited = 0;
        while (!axil_awready && waited < TIMEOUT)
        begin
            @(negedge clk);
            #SETTLE;
            waited++;
        end
        if (!axil_awready)
            note_timeout("write address ready");
        check_val("axil_wready", 32'(axil_wready), 32'd1);
        @(negedge clk);
        axil_awvalid = 1'b0;
        axil_wvalid = 1'b0;
        #SETTLE;
        waited = 0;
        stalls = 0;
        while (!axil_bvalid && waited < TIMEOUT)
        begin
            if (i_dut.stall)
                stalls++;
            @(negedge clk);
            #SETTLE;
            waited++;
        end
        if (!axil_bvalid)
            note_timeout("write response");
        resp = axil_bresp;
        repeat (hold)
        begin
            @(negedge clk);
            #SETTLE;
            check_val("axil_bvalid", 32'(axil_bvalid), 32'd1);
            check_val("axil_bresp", 32'(axil_bresp), 32'(resp));
        end
        @(negedge clk);
        axil_bready = 1'b1;
        @(negedge clk);
        axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] adr, input int hold,
                             output logic [31:0] dat, output logic [1:0] resp);
        int waited;
        @(negedge clk);
        axil_araddr = adr;
        axil_arvalid = 1'b1;
        axil_rready = 1'b0;
        #SETTLE;
        waited = 0;
        while (!axil_arready && waited < TIMEOUT)
        begin
            @(negedge clk);
            #SETTLE;
            waited++;
        end
        if (!axil_arready)
            note_timeout("read address ready");
        @(negedge clk);
        axil_arvalid = 1'b0;
        #SETTLE;
        waited = 0;
        while (!axil_rvalid && waited < TIMEOUT)
        begin
            @(negedge clk);
            #SETTLE;
            waited++;
        end
        if (!axil_rvalid)
            note_timeout("read response");
        dat = axil_rdata;
        resp = axil_rresp;
        repeat (hold)
        begin
            @(negedge clk);
            #SETTLE;
            check_val("axil_rvalid", 32'(axil_rvalid), 32'd1);
            check_val("axil_rdata", axil_rdata, dat);
        end
        @(negedge clk);
        axil_rready = 1'b1;
        @(negedge clk);
        axil_rready = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] off, input logic [31:0] val);
        logic [1:0] resp;
        int         stalls;
        axil_write(off, val, 0, resp, stalls);
        check_val("axil_bresp", 32'(resp), 32'(`MOS_AXI_RESP_OKAY));
    endtask

    task automatic read_reg(input logic [7:0] off, output logic [31:0] val);
        logic [1:0] resp;
        axil_read(off, 0, val, resp);
        check_val("axil_rresp", 32'(resp), 32'(`MOS_AXI_RESP_OKAY));
    endtask

    // a long write answers only after its stall, one cycle per byte
    task automatic mem_store(input logic [15:0] adr, input logic [1:0] cnt,
                             input logic [23:0] dat);
        logic [1:0] resp;
        int         stalls;
        int         exp_stalls;
        write_reg(`MOS_REG_ADDR, {16'h0000, adr});
        axil_write(`MOS_REG_WDATA, {6'd0, cnt, dat}, 0, resp, stalls);
        exp_stalls = (cnt >= 2'd2) ? int'(cnt) : 0;
        check_val("axil_bresp", 32'(resp), 32'(`MOS_AXI_RESP_OKAY));
        check_val("stall cycles", 32'(stalls), 32'(exp_stalls));
        for (int k = 0; k < int'(cnt); k++)
            model[adr + 16'(k)] = dat[8*k +: 8];
    endtask

    task automatic check_mem(input logic [15:0] adr);
        logic [31:0] got;
        write_reg(`MOS_REG_ADDR, {16'h0000, adr});
        read_reg(`MOS_REG_RDATA, got);
        check_val("axil_rdata", got, {24'h000000, model[adr]});
    endtask

    task automatic check_instr(input logic [15:0] pc, input bit check_ptr);
        logic [7:0]     op;
        logic [1:0]     len;
        logic           legal;
        logic [15:0]    operand;
        logic [15:0]    ptr;
        logic [31:0]    got;
        op = model[pc];
        len = op_len(op);
        legal = (len != 2'd0);
        if (!legal)
            len = 2'd1;
        case (len)
            2'd2: operand = {8'h00, model[pc + 16'd1]};
            2'd3: operand = {model[pc + 16'd2], model[pc + 16'd1]};
            default: operand = 16'h0000;
        endcase
        write_reg(`MOS_REG_PC, {16'h0000, pc});
        read_reg(`MOS_REG_DECODE, got);
        check_val("decode", got, {legal, 5'd0, len, operand, op});
        if (check_ptr)
        begin
            ptr = (len == 2'd1) ? 16'h0000 : {model[operand + 16'd1], model[operand]};
            read_reg(`MOS_REG_POINTER, got);
            check_val("pointer", got, {16'h0000, ptr});
        end
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial
    begin
        logic [31:0]    r;
        logic [31:0]    dat;
        logic [15:0]    adr;
        logic [15:0]    ind;
        logic [1:0]     resp;
        logic [1:0]     cnt;
        int             stalls;

        lfsr_q = 32'hedd5_c4f3;
        checks = 0;
        errors = 0;
        timeouts = 0;
        checks_mark = 0;
        errors_mark = 0;
        reset = 1'b1;
        axil_awaddr = '0;
        axil_awvalid = 1'b0;
        axil_wdata = '0;
        axil_wvalid = 1'b0;
        axil_bready = 1'b0;
        axil_araddr = '0;
        axil_arvalid = 1'b0;
        axil_rready = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        check_val("axil_bvalid", 32'(axil_bvalid), 32'd0);
        check_val("axil_rvalid", 32'(axil_rvalid), 32'd0);
        read_reg(`MOS_REG_PC, dat);
        check_val("pc", dat, 32'd0);
        read_reg(`MOS_REG_ADDR, dat);
        check_val("addr", dat, 32'd0);
        finish_test("reset values");

        for (int i = 0; i < 8; i++)
        begin
            draw_bits(16, r);
            adr = r[15:0];
            draw_bits(24, dat);
            mem_store(adr, 2'd1, dat[23:0]);
            check_mem(adr);
        end
        finish_test("single-byte writes");

        for (int i = 0; i < 6; i++)
        begin
            cnt = (i % 2 == 0) ? 2'd2 : 2'd3;
            draw_bits(16, r);
            adr = r[15:0];
            draw_bits(24, dat);
            mem_store(adr, cnt, dat[23:0]);
            for (int k = 0; k < int'(cnt); k++)
                check_mem(adr + 16'(k));
        end
        // a zero count must leave the last three bytes alone
        draw_bits(24, dat);
        mem_store(adr, 2'd0, dat[23:0]);
        for (int k = 0; k < 3; k++)
            check_mem(adr + 16'(k));
        finish_test("multi-byte writes");

        // LDY #$05, LDA $1234, TAX, BNE, JMP ($0400), then an illegal byte
        mem_store(16'h0200, 2'd2, 24'h0005A0);
        mem_store(16'h0202, 2'd3, 24'h1234AD);
        mem_store(16'h0205, 2'd1, 24'h0000AA);
        mem_store(16'h0206, 2'd2, 24'h00FAD0);
        mem_store(16'h0208, 2'd3, 24'h04006C);
        mem_store(16'h020B, 2'd1, 24'h000002);
        check_instr(16'h0200, 1'b0);
        check_instr(16'h0202, 1'b0);
        check_instr(16'h0205, 1'b0);
        check_instr(16'h0206, 1'b0);
        check_instr(16'h0208, 1'b0);
        check_instr(16'h020B, 1'b0);
        finish_test("decoding");

        // the word planted at ffff takes its high byte from address 0
        draw_bits(16, r);
        mem_store(16'h0300, 2'd2, 24'h0080A5);
        mem_store(16'h0080, 2'd2, {8'h00, r[15:0]});
        draw_bits(16, r);
        mem_store(16'h0302, 2'd3, 24'hFFFF6C);
        mem_store(16'hFFFF, 2'd2, {8'h00, r[15:0]});
        draw_bits(16, r);
        ind = {1'b1, r[14:0]};
        draw_bits(16, r);
        mem_store(16'h0305, 2'd3, {ind, 8'h6C});
        mem_store(ind, 2'd2, {8'h00, r[15:0]});
        check_instr(16'h0300, 1'b1);
        check_instr(16'h0302, 1'b1);
        check_instr(16'h0305, 1'b1);
        check_instr(16'h0205, 1'b1);
        finish_test("pointer resolution");

        axil_write(8'h18, 32'h0000_1234, 0, resp, stalls);
        check_val("axil_bresp", 32'(resp), 32'(`MOS_AXI_RESP_SLVERR));
        axil_read(8'h1C, 0, dat, resp);
        check_val("axil_rresp", 32'(resp), 32'(`MOS_AXI_RESP_SLVERR));
        check_val("axil_rdata", dat, 32'd0);
        axil_write(`MOS_REG_PC, 32'h0000_0302, 6, resp, stalls);
        check_val("axil_bresp", 32'(resp), 32'(`MOS_AXI_RESP_OKAY));
        axil_read(`MOS_REG_PC, 6, dat, resp);
        check_val("axil_rresp", 32'(resp), 32'(`MOS_AXI_RESP_OKAY));
        check_val("axil_rdata", dat, 32'h0000_0302);
        finish_test("protocol");

        $display("total checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
